/* rtl/core_pkg.sv */
// Core package with sizes, opcodes, host register map and instruction layout
package core_pkg;

	// Datapath and register file sizes
	localparam int W_DATA     = 32;
	localparam int N_REGS     = 16;
	localparam int W_REG_ADDR = $clog2(N_REGS);
	localparam int W_IMM      = 20;

	// R-type opcodes, second operand from rs2
	localparam logic [3:0] OP_ADD  = 4'd0;
	localparam logic [3:0] OP_SUB  = 4'd1;
	localparam logic [3:0] OP_AND  = 4'd2;
	localparam logic [3:0] OP_OR   = 4'd3;
	localparam logic [3:0] OP_XOR  = 4'd4;
	localparam logic [3:0] OP_SLL  = 4'd5;
	localparam logic [3:0] OP_SRL  = 4'd6;
	localparam logic [3:0] OP_SLT  = 4'd7;

	// I-type opcodes, top bit set, 12 to 15 are illegal
	localparam logic [3:0] OP_ADDI = 4'd8;
	localparam logic [3:0] OP_ANDI = 4'd9;
	localparam logic [3:0] OP_ORI  = 4'd10;
	localparam logic [3:0] OP_XORI = 4'd11;

	// APB register map
	localparam logic [11:0] ADDR_INSTR    = 12'h000;
	localparam logic [11:0] ADDR_STATUS   = 12'h004;
	localparam logic [11:0] ADDR_RESULT   = 12'h008;
	localparam logic [11:0] ADDR_REG_BASE = 12'h040;

	// Register-register view
	typedef struct packed {
		logic [3:0]            op;
		logic [W_REG_ADDR-1:0] rd;
		logic [W_REG_ADDR-1:0] rs1;
		logic [W_REG_ADDR-1:0] rs2;
		logic [15:0]           unused;
	} instr_r_t;

	// Register-immediate view
	typedef struct packed {
		logic [3:0]            op;
		logic [W_REG_ADDR-1:0] rd;
		logic [W_REG_ADDR-1:0] rs1;
		logic [W_IMM-1:0]      imm;
	} instr_i_t;

	// One instruction word, read through either view
	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_t;

endpackage

/* rtl/reg_file_1w2r.sv */
// Register file, one write port and two registered read ports, reset to zero
`timescale 1ns/1ps

module reg_file_1w2r (
	input  logic                           clk,
	input  logic                           rst_n,

	input  logic [core_pkg::W_REG_ADDR-1:0] raddr1,
	output logic [core_pkg::W_DATA-1:0]     rdata1,

	input  logic [core_pkg::W_REG_ADDR-1:0] raddr2,
	output logic [core_pkg::W_DATA-1:0]     rdata2,

	input  logic [core_pkg::W_REG_ADDR-1:0] waddr,
	input  logic [core_pkg::W_DATA-1:0]     wdata,
	input  logic                           wen
);

	import core_pkg::*;

	// Flop storage, small enough that reset costs little
	logic [W_DATA-1:0] mem [N_REGS];

	// Write port
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < N_REGS; i++) begin
				mem[i] <= '0;
			end
		end else if (wen) begin
			mem[waddr] <= wdata;
		end
	end

	// Read ports sample the old contents, no bypass from the write port
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rdata1 <= '0;
			rdata2 <= '0;
		end else begin
			rdata1 <= mem[raddr1];
			rdata2 <= mem[raddr2];
		end
	end

endmodule

/* rtl/instr_decode.sv */
// Instruction decode, latches an issued word and drives operand addresses and fields
`timescale 1ns/1ps

module instr_decode (
	input  logic                            clk,
	input  logic                            rst_n,

	// From the host port
	input  logic                            issue,
	input  core_pkg::instr_t                instr,
	input  logic                            host_rsel,
	input  logic [core_pkg::W_REG_ADDR-1:0] host_raddr,

	// To the register file
	output logic [core_pkg::W_REG_ADDR-1:0] raddr1,
	output logic [core_pkg::W_REG_ADDR-1:0] raddr2,

	// To execute
	output logic [3:0]                      op,
	output logic [core_pkg::W_DATA-1:0]     imm,
	output logic [core_pkg::W_REG_ADDR-1:0] rd,
	output logic                            dec_valid
);

	import core_pkg::*;

	instr_t instr_q;
	logic   is_itype;
	logic   idle;

	// Hold the word until the next issue, execute still reads its fields two cycles later
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			instr_q   <= '0;
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= issue;
			if (issue) begin
				instr_q <= instr;
			end
		end
	end

	// Top opcode bit marks the immediate class
	assign is_itype = instr_q.r.op[3];
	assign op       = instr_q.r.op;

	// Nothing issued and nothing waiting on read data
	assign idle = !issue && !dec_valid;

	always_comb begin
		if (is_itype) begin
			rd     = instr_q.i.rd;
			raddr2 = '0;
			// Sign-extend the 20-bit immediate
			imm    = {{(W_DATA-W_IMM){instr_q.i.imm[W_IMM-1]}}, instr_q.i.imm};
		end else begin
			rd     = instr_q.r.rd;
			raddr2 = instr_q.r.rs2;
			imm    = '0;
		end
	end

	// Read port 1 is lent to the host only when no instruction needs it
	assign raddr1 = (idle && host_rsel) ? host_raddr : instr_q.r.rs1;

endmodule

/* rtl/alu_execute.sv */
// ALU execute stage, picks the second operand and registers the result
`timescale 1ns/1ps

module alu_execute (
	input  logic                            clk,
	input  logic                            rst_n,

	// From decode
	input  logic                            dec_valid,
	input  logic [3:0]                      op,
	input  logic [core_pkg::W_DATA-1:0]     imm,
	input  logic [core_pkg::W_REG_ADDR-1:0] rd,

	// From the register file, one cycle after decode
	input  logic [core_pkg::W_DATA-1:0]     rdata1,
	input  logic [core_pkg::W_DATA-1:0]     rdata2,

	// To writeback
	output logic [core_pkg::W_DATA-1:0]     alu_result,
	output logic [core_pkg::W_REG_ADDR-1:0] alu_rd,
	output logic                            ex_valid,
	output logic                            ex_illegal
);

	import core_pkg::*;

	logic              opnd_valid;
	logic [W_DATA-1:0] opnd_b;
	logic [W_DATA-1:0] alu_next;
	logic              illegal_next;

	// Immediate class uses imm in place of rs2
	assign opnd_b = op[3] ? imm : rdata2;

	always_comb begin
		illegal_next = 1'b0;
		case (op)
			OP_ADD, OP_ADDI: alu_next = rdata1 + opnd_b;
			OP_SUB:          alu_next = rdata1 - opnd_b;
			OP_AND, OP_ANDI: alu_next = rdata1 & opnd_b;
			OP_OR, OP_ORI:   alu_next = rdata1 | opnd_b;
			OP_XOR, OP_XORI: alu_next = rdata1 ^ opnd_b;
			// Shift amount is the low 5 bits only
			OP_SLL:          alu_next = rdata1 << opnd_b[4:0];
			OP_SRL:          alu_next = rdata1 >> opnd_b[4:0];
			OP_SLT:          alu_next = {{(W_DATA-1){1'b0}}, $signed(rdata1) < $signed(opnd_b)};
			default: begin
				// Opcodes 12 to 15
				alu_next     = '0;
				illegal_next = 1'b1;
			end
		endcase
	end

	// Operands arrive a cycle after dec_valid, delay the valid to match
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			opnd_valid <= 1'b0;
			ex_valid   <= 1'b0;
			ex_illegal <= 1'b0;
		end else begin
			opnd_valid <= dec_valid;
			ex_valid   <= opnd_valid;
			ex_illegal <= opnd_valid && illegal_next;
		end
	end

	// Result payload, qualified by ex_valid downstream
	always_ff @(posedge clk) begin
		if (opnd_valid) begin
			alu_result <= alu_next;
			alu_rd     <= rd;
		end
	end

endmodule

/* rtl/result_writeback.sv */
// Result writeback, drives the register write and keeps RESULT and the illegal flag
`timescale 1ns/1ps

module result_writeback (
	input  logic                            clk,
	input  logic                            rst_n,

	// From execute
	input  logic                            ex_valid,
	input  logic                            ex_illegal,
	input  logic [core_pkg::W_DATA-1:0]     alu_result,
	input  logic [core_pkg::W_REG_ADDR-1:0] alu_rd,

	// Host write of 1 to STATUS bit1
	input  logic                            clr_illegal,

	// Register file write port
	output logic                            wen,
	output logic [core_pkg::W_REG_ADDR-1:0] waddr,
	output logic [core_pkg::W_DATA-1:0]     wdata,

	// Host visible state
	output logic [core_pkg::W_DATA-1:0]     result,
	output logic                            illegal,
	output logic                            retire
);

	import core_pkg::*;

	logic good;

	// Legal instruction leaving execute
	assign good = ex_valid && !ex_illegal;

	// Register 0 stays zero, its writes are dropped here
	assign wen   = good && (alu_rd != '0);
	assign waddr = alu_rd;
	assign wdata = alu_result;

	// Every instruction retires, legal or not
	assign retire = ex_valid;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result <= '0;
		end else if (good) begin
			// Updates even when rd is 0
			result <= alu_result;
		end
	end

	// Sticky flag, a new illegal instruction wins over a clear in the same cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			illegal <= 1'b0;
		end else if (ex_valid && ex_illegal) begin
			illegal <= 1'b1;
		end else if (clr_illegal) begin
			illegal <= 1'b0;
		end
	end

endmodule

/* rtl/apb_host_port.sv */
// APB3 host port, issues instructions with back-pressure and serves status and register reads
`timescale 1ns/1ps

module apb_host_port (
	input  logic                            clk,
	input  logic                            rst_n,

	// APB3 slave
	input  logic                            psel,
	input  logic                            penable,
	input  logic                            pwrite,
	input  logic [11:0]                     paddr,
	input  logic [core_pkg::W_DATA-1:0]     pwdata,
	output logic [core_pkg::W_DATA-1:0]     prdata,
	output logic                            pready,
	output logic                            pslverr,

	// From writeback and the register file
	input  logic                            retire,
	input  logic [core_pkg::W_DATA-1:0]     result,
	input  logic                            illegal,
	input  logic [core_pkg::W_DATA-1:0]     rdata1,

	// To decode
	output logic                            issue,
	output core_pkg::instr_t                instr,
	output logic                            host_rsel,
	output logic [core_pkg::W_REG_ADDR-1:0] host_raddr,

	// To writeback
	output logic                            clr_illegal
);

	import core_pkg::*;

	logic access;
	logic is_instr;
	logic is_status;
	logic is_result;
	logic is_reg;
	logic instr_go;
	logic reg_rd;
	logic busy;
	logic reg_phase;

	// Address decode, register window is 0x040 to 0x07c, word aligned
	assign access    = psel && penable;
	assign is_instr  = (paddr == ADDR_INSTR);
	assign is_status = (paddr == ADDR_STATUS);
	assign is_result = (paddr == ADDR_RESULT);
	assign is_reg    = (paddr[11:6] == ADDR_REG_BASE[11:6]) && (paddr[1:0] == 2'b00);

	// Instruction accepted only when the engine is free
	assign instr_go = access && pwrite && is_instr && !busy;
	assign reg_rd   = access && !pwrite && is_reg;

	// Borrow read port 1 while idle
	assign host_rsel   = reg_rd && !busy;
	assign host_raddr  = paddr[W_REG_ADDR+1:2];
	assign clr_illegal = access && pwrite && is_status && pwdata[1];

	// Busy from the accepting edge until retire
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy      <= 1'b0;
			issue     <= 1'b0;
			reg_phase <= 1'b0;
		end else begin
			issue     <= instr_go;
			// Second cycle of a register read, cleared after it completes
			reg_phase <= host_rsel && !reg_phase;
			if (instr_go) begin
				busy <= 1'b1;
			end else if (retire) begin
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (instr_go) begin
			instr <= pwdata;
		end
	end

	// Wait states, INSTR writes and register reads stall while busy
	always_comb begin
		if (!access) begin
			pready = 1'b0;
		end else if (pwrite && is_instr) begin
			pready = !busy;
		end else if (!pwrite && is_reg) begin
			pready = reg_phase;
		end else begin
			pready = 1'b1;
		end
	end

	// Errors only for writes into read-only space
	assign pslverr = access && pwrite && (is_result || is_reg);

	always_comb begin
		if (is_status) begin
			prdata = {{(W_DATA-2){1'b0}}, illegal, busy};
		end else if (is_result) begin
			prdata = result;
		end else if (is_reg) begin
			prdata = rdata1;
		end else begin
			prdata = '0;
		end
	end

endmodule

/* rtl/mini_alu_core.sv */
// Mini ALU core top level, APB host port feeding decode, execute, writeback and registers
`timescale 1ns/1ps

module mini_alu_core (
	input  logic                        clk,
	input  logic                        rst_n,

	input  logic                        psel,
	input  logic                        penable,
	input  logic                        pwrite,
	input  logic [11:0]                 paddr,
	input  logic [core_pkg::W_DATA-1:0] pwdata,
	output logic [core_pkg::W_DATA-1:0] prdata,
	output logic                        pready,
	output logic                        pslverr
);

	import core_pkg::*;

	// Host port to decode
	logic                  issue;
	instr_t                instr;
	logic                  host_rsel;
	logic [W_REG_ADDR-1:0] host_raddr;
	logic                  clr_illegal;

	// Decode outputs
	logic [W_REG_ADDR-1:0] raddr1;
	logic [W_REG_ADDR-1:0] raddr2;
	logic [3:0]            op;
	logic [W_DATA-1:0]     imm;
	logic [W_REG_ADDR-1:0] rd;
	logic                  dec_valid;

	// Register file and execute
	logic [W_DATA-1:0]     rdata1;
	logic [W_DATA-1:0]     rdata2;
	logic [W_DATA-1:0]     alu_result;
	logic [W_REG_ADDR-1:0] alu_rd;
	logic                  ex_valid;
	logic                  ex_illegal;

	// Writeback
	logic                  wen;
	logic [W_REG_ADDR-1:0] waddr;
	logic [W_DATA-1:0]     wdata;
	logic [W_DATA-1:0]     result;
	logic                  illegal;
	logic                  retire;

	apb_host_port u_apb_host_port (
		.clk, .rst_n,
		.psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
		.retire, .result, .illegal, .rdata1,
		.issue, .instr, .host_rsel, .host_raddr, .clr_illegal
	);

	instr_decode u_instr_decode (
		.clk, .rst_n,
		.issue, .instr, .host_rsel, .host_raddr,
		.raddr1, .raddr2, .op, .imm, .rd, .dec_valid
	);

	reg_file_1w2r u_reg_file_1w2r (
		.clk, .rst_n,
		.raddr1, .rdata1, .raddr2, .rdata2,
		.waddr, .wdata, .wen
	);

	alu_execute u_alu_execute (
		.clk, .rst_n,
		.dec_valid, .op, .imm, .rd, .rdata1, .rdata2,
		.alu_result, .alu_rd, .ex_valid, .ex_illegal
	);

	result_writeback u_result_writeback (
		.clk, .rst_n,
		.ex_valid, .ex_illegal, .alu_result, .alu_rd, .clr_illegal,
		.wen, .waddr, .wdata, .result, .illegal, .retire
	);

endmodule

/* testbench/tb_mini_alu_core.sv */
// Mini ALU core testbench replaying APB commands and expected values from a stimulus file
`timescale 1ns/1ps

module tb_mini_alu_core;

	// Clock and run limits
	localparam int    CLK_PERIOD     = 4;
	localparam int    RESET_CYCLES   = 3;
	localparam int    CYCLES_PER_CMD = 40;
	localparam string STIM_FILE      = "testbench/alu_stimulus.txt";

	logic        clk = 1'b0;
	logic        rst_n;

	// APB3 master side
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [11:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;

	// Parsed stimulus with one entry per command line
	logic [7:0]      cmd_q[$];
	logic [11:0]     addr_q[$];
	logic [31:0]     data_q[$];
	logic [8*24-1:0] name_q[$];

	logic [31:0] lcg_state;
	logic        loaded = 1'b0;

	mini_alu_core u_mini_alu_core (
		.clk,
		.rst_n,
		.psel,
		.penable,
		.pwrite,
		.paddr,
		.pwdata,
		.prdata,
		.pready,
		.pslverr
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// 32-bit LCG whose top bits give the idle count
	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic abort_run();
		$display("TEST FAILED");
		$fatal(1, "Simulation stopped on error");
	endtask

	// Compare one value and stop at the first mismatch
	task automatic check_value(input logic [8*24-1:0] name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("ERR %0s: expected %08h actual %08h", name, expected, actual);
			abort_run();
		end
	endtask

	// Bus idle for n cycles from one falling edge to another
	task automatic idle_cycles(input int n);
		psel    = 1'b0;
		penable = 1'b0;
		repeat (n) @(negedge clk);
	endtask

	// One APB transfer started on a falling edge
	task automatic apb_transfer(input logic wr, input logic [11:0] addr,
			input logic [31:0] data, output logic [31:0] rd_data, output logic err);
		// Setup phase
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = data;
		@(negedge clk);
		// Access phase held until pready
		penable = 1'b1;
		// Sample in the low phase well clear of the rising edge
		#1;
		while (!pready) begin
			@(negedge clk);
			#1;
		end
		rd_data = prdata;
		err     = pslverr;
		// Transfer completes on the next rising edge
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	// Read command lines and skip hash and blank lines
	task automatic load_stimulus();
		int              fd;
		int              code;
		int              n;
		int              line_no;
		string           line;
		logic [7:0]      c;
		logic [11:0]     a;
		logic [31:0]     d;
		logic [8*24-1:0] nm;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("Cannot open stimulus file %s", STIM_FILE);
			abort_run();
		end else begin
			line_no = 0;
			code = $fgets(line, fd);
			while (code > 0) begin
				line_no++;
				if (line.len() > 1 && line.getc(0) != "#") begin
					n = $sscanf(line, "%c %h %h %s", c, a, d, nm);
					if (n != 4 || !(c inside {"W", "B", "E", "R"})) begin
						$display("Malformed stimulus line %0d: %s", line_no, line);
						abort_run();
					end else begin
						cmd_q.push_back(c);
						addr_q.push_back(a);
						data_q.push_back(d);
						name_q.push_back(nm);
					end
				end
				code = $fgets(line, fd);
			end
			$fclose(fd);
		end
	endtask

	// Main sequence
	initial begin
		logic [31:0] rdata;
		logic        err;
		psel      = 1'b0;
		penable   = 1'b0;
		pwrite    = 1'b0;
		paddr     = '0;
		pwdata    = '0;
		rst_n     = 1'b0;
		lcg_state = 32'd51371;
		load_stimulus();
		loaded = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		foreach (cmd_q[i]) begin
			// B lines follow the previous transfer with no idle cycle
			if (cmd_q[i] != "B") begin
				lcg_state = lcg_next(lcg_state);
				idle_cycles(int'(lcg_state[31:30]));
			end
			if (cmd_q[i] == "R") begin
				apb_transfer(1'b0, addr_q[i], 32'd0, rdata, err);
				check_value(name_q[i], data_q[i], rdata);
			end else begin
				apb_transfer(1'b1, addr_q[i], data_q[i], rdata, err);
				// E expects an error response and W or B expects none
				check_value(name_q[i], (cmd_q[i] == "E") ? 32'd1 : 32'd0, {31'd0, err});
			end
		end
		idle_cycles(2);
		$display("TEST PASSED");
		$finish;
	end

	// Watchdog sized from the number of command lines
	initial begin
		int limit;
		wait (loaded);
		limit = cmd_q.size() * CYCLES_PER_CMD + RESET_CYCLES + 10;
		repeat (limit) @(posedge clk);
		$display("Run timed out, not finished after %0d cycles", limit);
		abort_run();
	end

endmodule

/* compile.f */
rtl/core_pkg.sv
rtl/reg_file_1w2r.sv
rtl/instr_decode.sv
rtl/alu_execute.sv
rtl/result_writeback.sv
rtl/apb_host_port.sv
rtl/mini_alu_core.sv
testbench/tb_mini_alu_core.sv

/* run_sim.sh */
#!/bin/sh
# Builds the mini ALU core testbench with Verilator and runs it.
# The exit status is the simulator's, so a failing test makes this script fail.

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

verilator --binary --timing --timescale 1ns/1ps -j 0 \
	--top-module tb_mini_alu_core \
	-f compile.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/Vtb_mini_alu_core
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

exit 0

/* testbench/alu_stimulus.txt */
# cmd addr data name: W write, B write with no idle before it, E write expecting pslverr
# R read, its data column is the expected value. Register n is at 0x040 + 4n
R 004 00000000 rst_status
R 008 00000000 rst_result
R 040 00000000 rst_r0
R 044 00000000 rst_r1
R 060 00000000 rst_r8
R 07C 00000000 rst_r15
# I-type, sign-extended immediates
W 000 810FFFFB addi_r1_neg
W 000 8207FFFF addi_r2_pos
W 000 83012345 addi_r3
W 000 941800F0 andi_r4
W 000 A5300F00 ori_r5
W 000 B62FFFFF xori_r6
R 044 FFFFFFFB rd_r1
R 048 0007FFFF rd_r2
R 04C 00012345 rd_r3
R 050 FFF800F0 rd_r4
R 054 00012F45 rd_r5
R 058 FFF80000 rd_r6
# R-type
W 000 07120000 add_r7
R 05C 0007FFFA rd_r7
R 008 0007FFFA res_add
W 000 18320000 sub_r8
R 060 FFF92346 rd_r8
W 000 29510000 and_r9
W 000 3A430000 or_r10
W 000 4B150000 xor_r11
R 064 00012F41 rd_r9
R 068 FFF923F5 rd_r10
R 06C FFFED0BE rd_r11
W 000 5C310000 sll_r12
W 000 6D690000 srl_r13
R 070 28000000 rd_r12
R 074 7FFC0000 rd_r13
W 000 7E120000 slt_r14
R 078 00000001 rd_r14
R 008 00000001 res_slt_true
W 000 7F210000 slt_r15
R 07C 00000000 rd_r15
R 008 00000000 res_slt_false
# Back-to-back dependent instructions
W 000 81000003 b2b_addi_r1
B 000 02110000 b2b_add_r2
B 000 13210000 b2b_sub_r3
B 000 54230000 b2b_sll_r4
R 050 00000030 b2b_rd_r4
R 008 00000030 b2b_result
R 048 00000006 b2b_rd_r2
R 04C 00000003 b2b_rd_r3
# Illegal opcode and sticky flag
W 000 C5120000 illegal_op
R 054 00012F45 ill_rd_r5
R 004 00000002 ill_status
R 008 00000030 ill_result
W 004 00000001 status_no_clr
R 004 00000002 ill_still_set
W 004 00000002 status_clr
R 004 00000000 ill_cleared
# Register 0 and read-only space
W 000 80000055 addi_r0
R 040 00000000 r0_still_zero
R 008 00000055 r0_result
E 008 12345678 wr_result_err
E 044 DEADBEEF wr_reg_err
R 044 00000003 r1_unchanged
R 008 00000055 result_unchanged
R 004 00000000 final_status
